//--- hdl/stream_pkg.sv
package stream_pkg;

    // Occupancy of a two-register skid buffer.
    // Only the side register holding data is not a legal state.
    typedef enum logic [1:0] {
        skid_empty = 2'd0,  // Output and side registers empty.
        skid_busy  = 2'd1,  // Output register holds a beat.
        skid_full  = 2'd2   // Output and side registers both hold a beat.
    } skid_state_e;

    // Mode of the packet arbiter.
    typedef enum logic {
        arb_idle   = 1'b0,  // Free to pick a new source.
        arb_locked = 1'b1   // Held on one source until its last beat.
    } arb_state_e;

endpackage

//--- hdl/stream_if.sv
`timescale 1ns/1ps

// One valid/ready stream link with packet framing and a source tag.
interface stream_if #(
    parameter int WORD_WIDTH = 16,  // Payload width.
    parameter int SRC_WIDTH  = 1    // Source tag width.
);

    logic                   valid;  // Beat offered by the sender.
    logic                   ready;  // Receiver can take a beat.
    logic [WORD_WIDTH-1:0]  data;   // Payload word.
    logic                   last;   // Final beat of a packet.
    logic [SRC_WIDTH-1:0]   src;    // Number of the source port.

    modport sender (
        output valid,
        output data,
        output last,
        output src,
        input  ready
    );

    modport receiver (
        input  valid,
        input  data,
        input  last,
        input  src,
        output ready
    );

endinterface

//--- hdl/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter int WIDTH = 16  // Width of the packed beat.
) (
    input  logic                clock,
    input  logic                rst_n,

    input  logic                in_valid,
    output logic                in_ready,
    input  logic [WIDTH-1:0]    in_data,

    output logic                out_valid,
    input  logic                out_ready,
    output logic [WIDTH-1:0]    out_data
);

    stream_pkg::skid_state_e state_q;  // Current occupancy.
    stream_pkg::skid_state_e state_d;  // Occupancy after this edge.

    logic [WIDTH-1:0] side_q;  // Side register for the extra beat.

    logic insert;  // Beat accepted at the input.
    logic remove;  // Beat taken at the output.

    logic load;    // Empty buffer takes a beat into the output register.
    logic flow;    // New beat replaces the one leaving.
    logic fill;    // New beat parks in the side register.
    logic flush;   // Side register moves to the output.
    logic unload;  // Last held beat leaves.

    logic out_wren;   // Output register write enable.
    logic side_wren;  // Side register write enable.

    always_comb begin
        insert = in_valid && in_ready;
        remove = out_valid && out_ready;
    end

    always_comb begin
        load   = (state_q == stream_pkg::skid_empty) && insert && !remove;
        flow   = (state_q == stream_pkg::skid_busy)  && insert && remove;
        fill   = (state_q == stream_pkg::skid_busy)  && insert && !remove;
        flush  = (state_q == stream_pkg::skid_full)  && !insert && remove;
        unload = (state_q == stream_pkg::skid_busy)  && !insert && remove;
    end

    // Next occupancy.
    always_comb begin
        state_d = state_q;  // Hold when nothing moves.
        if (load || flow || flush) begin
            state_d = stream_pkg::skid_busy;
        end
        if (fill) begin
            state_d = stream_pkg::skid_full;  // Ready drops on the next cycle.
        end
        if (unload) begin
            state_d = stream_pkg::skid_empty;
        end
    end

    always_comb begin
        out_wren  = load || flow || flush;
        side_wren = fill;
    end

    // Control registers.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q   <= stream_pkg::skid_empty;
            in_ready  <= 1'b1;  // Empty after reset so take data.
            out_valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            in_ready  <= (state_d != stream_pkg::skid_full);
            out_valid <= (state_d != stream_pkg::skid_empty);
        end
    end

    // Payload registers.
    always_ff @(posedge clock) begin
        if (side_wren) begin
            side_q <= in_data;  // Beat that arrived while the output stalled.
        end
        if (out_wren) begin
            out_data <= flush ? side_q : in_data;
        end
    end

endmodule

//--- hdl/packet_arbiter.sv
`timescale 1ns/1ps

module packet_arbiter #(
    parameter int NUM_SOURCES = 4,   // Number of source links.
    parameter int WORD_WIDTH  = 16,  // Payload width.
    parameter int SRC_WIDTH   = 2    // Source tag width.
) (
    input  logic        clock,
    input  logic        rst_n,

    stream_if.receiver  src [NUM_SOURCES],  // Buffered source links.
    stream_if.sender    bus                 // Shared output link.
);

    stream_pkg::arb_state_e state_q;  // Idle or locked on a packet.

    logic [SRC_WIDTH-1:0] ptr_q;     // First source to try in idle.
    logic [SRC_WIDTH-1:0] ptr_next;  // Source after the current grant.
    logic [SRC_WIDTH-1:0] grant_q;   // Source held for the open packet.
    logic [SRC_WIDTH-1:0] pick;      // Round-robin choice.
    logic                 pick_found;
    logic [SRC_WIDTH-1:0] grant;     // Source on the bus this cycle.
    logic                 grant_ok;  // Grant points at a live source.
    logic                 accept;    // Beat moves on the bus.
    int                   rr_idx;    // Scan index with wrap.

    logic [NUM_SOURCES-1:0] src_valid;
    logic [NUM_SOURCES-1:0] src_last;
    logic [WORD_WIDTH-1:0]  src_data [NUM_SOURCES];
    logic [SRC_WIDTH-1:0]   src_tag  [NUM_SOURCES];

    // Flatten the link array so it can be indexed by the grant.
    for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_src
        assign src_valid[i] = src[i].valid;
        assign src_last[i]  = src[i].last;
        assign src_data[i]  = src[i].data;
        assign src_tag[i]   = src[i].src;
        // Only the granted source sees the bus ready.
        assign src[i].ready = bus.ready && grant_ok && (grant == SRC_WIDTH'(i));
    end

    // First valid source at or after the pointer.
    always_comb begin
        pick       = ptr_q;
        pick_found = 1'b0;
        rr_idx     = 0;
        for (int k = 0; k < NUM_SOURCES; k++) begin
            rr_idx = int'(ptr_q) + k;
            if (rr_idx >= NUM_SOURCES) begin
                rr_idx = rr_idx - NUM_SOURCES;  // Wrap past the top source.
            end
            if (!pick_found && src_valid[rr_idx]) begin
                pick       = SRC_WIDTH'(rr_idx);
                pick_found = 1'b1;
            end
        end
    end

    always_comb begin
        if (state_q == stream_pkg::arb_locked) begin
            grant    = grant_q;  // Stay on the open packet.
            grant_ok = 1'b1;
        end else begin
            grant    = pick;
            grant_ok = pick_found;
        end
    end

    always_comb begin
        if (int'(grant) == NUM_SOURCES - 1) begin
            ptr_next = '0;
        end else begin
            ptr_next = grant + 1'b1;
        end
    end

    // Shared bus is a straight mux of the granted link.
    assign bus.valid = grant_ok && src_valid[grant];
    assign bus.data  = src_data[grant];
    assign bus.last  = src_last[grant];
    assign bus.src   = src_tag[grant];

    assign accept = grant_ok && src_valid[grant] && bus.ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state_q <= stream_pkg::arb_idle;
            ptr_q   <= '0;  // Source 0 goes first.
            grant_q <= '0;
        end else begin
            case (state_q)
                stream_pkg::arb_idle: begin
                    if (accept) begin
                        ptr_q <= ptr_next;  // Next round starts after this source.
                        if (!src_last[grant]) begin
                            state_q <= stream_pkg::arb_locked;
                            grant_q <= grant;
                        end
                    end
                end
                stream_pkg::arb_locked: begin
                    if (accept && src_last[grant]) begin
                        state_q <= stream_pkg::arb_idle;  // Packet closed.
                    end
                end
                default: begin
                    state_q <= stream_pkg::arb_idle;
                end
            endcase
        end
    end

endmodule

//--- hdl/stream_merge_top.sv
`timescale 1ns/1ps

module stream_merge_top #(
    parameter  int NUM_SOURCES = 4,   // Number of source ports.
    parameter  int WORD_WIDTH  = 16,  // Payload width.
    localparam int SRC_WIDTH   = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1
) (
    input  logic                            clock,
    input  logic                            rst_n,

    input  logic [NUM_SOURCES-1:0]          in_valid,
    output logic [NUM_SOURCES-1:0]          in_ready,
    input  logic [NUM_SOURCES*WORD_WIDTH-1:0] in_data,
    input  logic [NUM_SOURCES-1:0]          in_last,

    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [WORD_WIDTH-1:0]           out_data,
    output logic                            out_last,
    output logic [SRC_WIDTH-1:0]            out_src
);

    localparam int IN_WIDTH  = WORD_WIDTH + 1;              // Last and data.
    localparam int OUT_WIDTH = WORD_WIDTH + SRC_WIDTH + 1;  // Last, source and data.

    stream_if #(
        .WORD_WIDTH (WORD_WIDTH),
        .SRC_WIDTH  (SRC_WIDTH)
    ) in_link [NUM_SOURCES] ();  // Buffered source links.

    stream_if #(
        .WORD_WIDTH (WORD_WIDTH),
        .SRC_WIDTH  (SRC_WIDTH)
    ) bus_link ();  // Shared bus after arbitration.

    logic [OUT_WIDTH-1:0] out_word;  // Packed beat leaving the output buffer.

    for (genvar i = 0; i < NUM_SOURCES; i++) begin : g_in
        logic [IN_WIDTH-1:0] in_word;  // Packed beat leaving this buffer.

        skid_buffer #(
            .WIDTH      (IN_WIDTH)
        ) u_in_skid (
            .clock      (clock),
            .rst_n      (rst_n),
            .in_valid   (in_valid[i]),
            .in_ready   (in_ready[i]),
            .in_data    ({in_last[i], in_data[i*WORD_WIDTH +: WORD_WIDTH]}),
            .out_valid  (in_link[i].valid),
            .out_ready  (in_link[i].ready),
            .out_data   (in_word)
        );

        assign in_link[i].last = in_word[WORD_WIDTH];
        assign in_link[i].data = in_word[WORD_WIDTH-1:0];
        assign in_link[i].src  = SRC_WIDTH'(i);  // Tag with the port number.
    end

    packet_arbiter #(
        .NUM_SOURCES    (NUM_SOURCES),
        .WORD_WIDTH     (WORD_WIDTH),
        .SRC_WIDTH      (SRC_WIDTH)
    ) u_arbiter (
        .clock          (clock),
        .rst_n          (rst_n),
        .src            (in_link),
        .bus            (bus_link.sender)
    );

    skid_buffer #(
        .WIDTH      (OUT_WIDTH)
    ) u_out_skid (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (bus_link.valid),
        .in_ready   (bus_link.ready),
        .in_data    ({bus_link.last, bus_link.src, bus_link.data}),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_word)
    );

    assign out_last = out_word[OUT_WIDTH-1];
    assign out_src  = out_word[WORD_WIDTH +: SRC_WIDTH];
    assign out_data = out_word[WORD_WIDTH-1:0];

endmodule

//--- dv/tb_stream_merge.sv
`timescale 1ns/1ps

module tb_stream_merge;

    localparam int NUM_SOURCES  = 4;
    localparam int WORD_WIDTH   = 16;
    localparam int SRC_WIDTH    = (NUM_SOURCES > 1) ? $clog2(NUM_SOURCES) : 1;
    localparam int MAX_BEATS    = 256;  // Capacity of each source list.
    localparam int STALL_CYCLES = 20;
    localparam int STALL_DEPTH  = 4;    // Own input skid pair plus the output skid pair.

    localparam int T_RESET      = 0;
    localparam int T_STALL      = 1;
    localparam int T_ORDER      = 2;
    localparam int T_INTERLEAVE = 3;
    localparam int T_FAIR       = 4;
    localparam int T_DONE       = 5;
    localparam int NUM_TESTS    = 6;

    localparam int PH_IDLE      = 0;  // Sources quiet and output stalled.
    localparam int PH_STALL     = 1;  // Sources always offer, output stalled.
    localparam int PH_RANDOM    = 2;  // Random offers and random out_ready.
    localparam int PH_DRAIN     = 3;  // Output always ready.

    logic                            clock = 1'b0;
    logic                            rst_n;
    logic [NUM_SOURCES-1:0]          in_valid;
    logic [NUM_SOURCES-1:0]          in_ready;
    logic [NUM_SOURCES*WORD_WIDTH-1:0] in_data;
    logic [NUM_SOURCES-1:0]          in_last;
    logic                            out_valid;
    logic                            out_ready;
    logic [WORD_WIDTH-1:0]           out_data;
    logic                            out_last;
    logic [SRC_WIDTH-1:0]            out_src;

    logic [WORD_WIDTH-1:0] beat_data [NUM_SOURCES][MAX_BEATS];  // Beats per source in file order.
    logic                  beat_last [NUM_SOURCES][MAX_BEATS];
    int src_count   [NUM_SOURCES];  // Beats listed for each source.
    int drive_idx   [NUM_SOURCES];  // Next beat to offer.
    int check_idx   [NUM_SOURCES];  // Next beat expected at the output.
    int accepted_in [NUM_SOURCES];  // Beats taken by the DUT so far.
    int seen_out    [NUM_SOURCES];  // Beats seen at the output so far.
    logic [NUM_SOURCES-1:0] taken;  // Beats accepted at the coming edge.

    int          total_beats = 0;
    int          seen_total  = 0;
    bit          load_done   = 1'b0;
    int          phase       = PH_IDLE;
    logic [31:0] rng_state;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          stall_total;
    int          test_errors [NUM_TESTS];
    string       test_names  [NUM_TESTS] = '{"reset_state", "back_pressure", "source_order",
                                             "no_interleave", "fairness", "completion"};

    bit                     pkt_open  = 1'b0;  // Output packet not closed yet.
    bit                     have_prev = 1'b0;
    logic [SRC_WIDTH-1:0]   prev_src;
    logic [NUM_SOURCES-1:0] wait_mask_1 = '0;  // Sources holding beats, one output beat ago.
    logic [NUM_SOURCES-1:0] wait_mask_2 = '0;  // Same, two output beats ago.

    stream_merge_top #(
        .NUM_SOURCES (NUM_SOURCES),
        .WORD_WIDTH  (WORD_WIDTH)
    ) dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_data     (in_data),
        .in_last     (in_last),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_last    (out_last),
        .out_src     (out_src)
    );

    always #2 clock = ~clock;  // 4 ns period.

    // LCG step with the usual 32-bit constants.
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_word(input int t, input logic [WORD_WIDTH-1:0] expected,
                              input logic [WORD_WIDTH-1:0] actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            test_errors[t]++;
            $display("CHECK FAILED %s: expected %h, actual %h", test_names[t], expected, actual);
        end
    endtask

    task automatic check_bit(input int t, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            test_errors[t]++;
            $display("CHECK FAILED %s: expected %b, actual %b", test_names[t], expected, actual);
        end
    endtask

    task automatic check_src(input int t, input logic [SRC_WIDTH-1:0] expected,
                             input logic [SRC_WIDTH-1:0] actual);
        if (actual === expected) begin
            pass_count++;
        end else begin
            fail_count++;
            test_errors[t]++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", test_names[t], expected, actual);
        end
    endtask

    task automatic report_failure(input int t, input string what);
        fail_count++;
        test_errors[t]++;
        $display("FAILURE in %s: %s", test_names[t], what);
    endtask

    task automatic report_test(input int t);
        if (test_errors[t] == 0) begin
            $display("TEST %s: finished with no errors", test_names[t]);
        end else begin
            $display("TEST %s: finished with %0d errors", test_names[t], test_errors[t]);
        end
    endtask

    // Reads the beat file into the per-source lists.
    task automatic load_patterns();
        int    fd;
        int    n;
        int    s;
        int    d;
        int    l;
        int    got;
        string line;
        fd = $fopen("dv/stream_merge_patterns.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got == 0 || line.len() == 0 || line.getc(0) == "#") begin
                continue;  // Comment or blank line.
            end
            n = $sscanf(line, "%h %h %h", s, d, l);
            if (n == 3 && s >= 0 && s < NUM_SOURCES && src_count[s] < MAX_BEATS) begin
                beat_data[s][src_count[s]] = d[WORD_WIDTH-1:0];
                beat_last[s][src_count[s]] = l[0];
                src_count[s]++;
                total_beats++;
            end
        end
        $fclose(fd);
    endtask

    // Scoreboard for one output beat sampled mid-cycle.
    task automatic observe_output();
        int                     s;
        logic [NUM_SOURCES-1:0] waiting;
        logic [NUM_SOURCES-1:0] others;
        if (!(out_valid && out_ready)) begin
            return;
        end
        s = int'(out_src);
        seen_total++;
        if (pkt_open) begin
            check_src(T_INTERLEAVE, prev_src, out_src);  // Packet still open.
        end else if (have_prev && out_src == prev_src) begin
            // Idle arbiter passed over sources that held beats before this one entered.
            others    = wait_mask_2;
            others[s] = 1'b0;
            if (others != '0) begin
                report_failure(T_FAIR, $sformatf(
                    "source %0d sent two packets in a row while sources %b were waiting",
                    s, others));
            end else begin
                pass_count++;
            end
        end
        seen_out[s]++;
        if (check_idx[s] >= src_count[s]) begin
            report_failure(T_ORDER, $sformatf("source %0d sent more beats than listed", s));
        end else begin
            check_word(T_ORDER, beat_data[s][check_idx[s]], out_data);
            check_bit(T_ORDER, beat_last[s][check_idx[s]], out_last);
            check_idx[s]++;
        end
        waiting = '0;
        for (int j = 0; j < NUM_SOURCES; j++) begin
            waiting[j] = (accepted_in[j] > seen_out[j]);  // Beats still inside the DUT.
        end
        wait_mask_2 = wait_mask_1;
        wait_mask_1 = waiting;
        pkt_open    = !out_last;
        prev_src    = out_src;
        have_prev   = 1'b1;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        bit          offer;
        for (int s = 0; s < NUM_SOURCES; s++) begin
            if (in_valid[s] && !taken[s]) begin
                continue;  // Hold the beat until the DUT takes it.
            end
            offer = 1'b0;
            if (drive_idx[s] < src_count[s]) begin
                if (phase == PH_STALL) begin
                    offer = 1'b1;
                end else if (phase == PH_RANDOM) begin
                    r     = next_rand();
                    offer = (r[31:30] != 2'b00);  // Offer three cycles in four.
                end
            end
            in_valid[s] = offer;
            if (offer) begin
                in_data[s*WORD_WIDTH +: WORD_WIDTH] = beat_data[s][drive_idx[s]];
                in_last[s] = beat_last[s][drive_idx[s]];
            end
        end
        r = next_rand();
        case (phase)
            PH_RANDOM: out_ready = (r[31:29] > 3'd2);
            PH_DRAIN:  out_ready = 1'b1;
            default:   out_ready = 1'b0;
        endcase
    endtask

    // Source and sink driver that changes inputs 1 ns after the rising edge.
    initial begin
        in_valid  = '0;
        in_data   = '0;
        in_last   = '0;
        out_ready = 1'b0;
        taken     = '0;
        rng_state = 32'h2ec7da4b;
        forever begin
            @(negedge clock);
            observe_output();
            for (int s = 0; s < NUM_SOURCES; s++) begin
                taken[s] = in_valid[s] && in_ready[s];
                if (taken[s]) begin
                    drive_idx[s]++;
                    accepted_in[s]++;
                end
            end
            @(posedge clock);
            #1;
            drive_inputs();
        end
    end

    initial begin
        wait (load_done);
        repeat (total_beats * 40 + 200) @(posedge clock);
        $display("Watchdog: the run timed out with %0d of %0d output beats seen.",
                 seen_total, total_beats);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        load_patterns();
        if (total_beats == 0) begin
            fail_count++;
            $display("No beats could be read from dv/stream_merge_patterns.txt.");
        end else begin
            load_done = 1'b1;
            repeat (2) @(posedge clock);
            #1;
            rst_n = 1'b1;
            @(negedge clock);
            for (int s = 0; s < NUM_SOURCES; s++) begin
                check_bit(T_RESET, 1'b1, in_ready[s]);
            end
            check_bit(T_RESET, 1'b0, out_valid);
            report_test(T_RESET);

            phase = PH_STALL;
            repeat (STALL_CYCLES) @(posedge clock);
            stall_total = 0;
            for (int s = 0; s < NUM_SOURCES; s++) begin
                stall_total += accepted_in[s];
                if (accepted_in[s] > STALL_DEPTH) begin
                    report_failure(T_STALL, $sformatf(
                        "source %0d took %0d beats while the output was stalled",
                        s, accepted_in[s]));
                end else begin
                    pass_count++;
                end
            end
            // Every skid register in the DUT ends up full.
            check_word(T_STALL, WORD_WIDTH'(2 * NUM_SOURCES + 2), WORD_WIDTH'(stall_total));
            report_test(T_STALL);

            phase = PH_RANDOM;
            wait (seen_total >= total_beats);
            phase = PH_DRAIN;
            repeat (10) @(posedge clock);
            @(negedge clock);
            check_bit(T_DONE, 1'b0, out_valid);
            check_word(T_DONE, WORD_WIDTH'(total_beats), WORD_WIDTH'(seen_total));
            for (int s = 0; s < NUM_SOURCES; s++) begin
                if (check_idx[s] != src_count[s]) begin
                    report_failure(T_DONE, $sformatf("source %0d delivered %0d of %0d beats",
                                                     s, check_idx[s], src_count[s]));
                end else begin
                    pass_count++;
                end
            end
            report_test(T_ORDER);
            report_test(T_INTERLEAVE);
            report_test(T_FAIR);
            report_test(T_DONE);
        end
        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- dv/stream_merge_patterns.txt
# Columns: source number (hex), data word (hex), last flag (0 or 1).
# One beat per line; beats of each source are sent in the order listed.
0 a000 0
1 b000 1
2 c000 0
3 d000 1
0 a001 0
1 b001 0
2 c001 0
3 d001 1
0 a002 1
1 b002 1
2 c002 0
3 d002 0
0 a003 1
1 b003 0
2 c003 1
3 d003 1
0 a004 0
1 b004 0
2 c004 1
3 d004 0
0 a005 0
1 b005 0
2 c005 0
3 d005 0
0 a006 0
1 b006 1
2 c006 1
3 d006 0
0 a007 1
1 b007 1
2 c007 0
3 d007 1
0 a008 1
1 b008 0
2 c008 1
0 a009 0
1 b009 1
0 a00a 1

//--- src.f
hdl/stream_pkg.sv
hdl/stream_if.sv
hdl/skid_buffer.sv
hdl/packet_arbiter.sv
hdl/stream_merge_top.sv
dv/tb_stream_merge.sv

//--- Bender.yml
package:
  name: stream_merge

sources:
  # RTL in compile order.
  - files:
      - hdl/stream_pkg.sv
      - hdl/stream_if.sv
      - hdl/skid_buffer.sv
      - hdl/packet_arbiter.sv
      - hdl/stream_merge_top.sv

  # Testbench.
  - target: simulation
    files:
      - dv/tb_stream_merge.sv
